//--- hdl/vchess_pkg.sv
package vchess_pkg;

   typedef logic [3:0] piece_t;      // Bit 3 set means Black
   typedef piece_t [7:0] rank_t;     // File a in the low nibble
   typedef rank_t [7:0] board_t;     // Rank 1 at index 0

   localparam logic [2:0] kind_pawn   = 3'd1;
   localparam logic [2:0] kind_knight = 3'd2;
   localparam logic [2:0] kind_bishop = 3'd3;
   localparam logic [2:0] kind_rook   = 3'd4;
   localparam logic [2:0] kind_queen  = 3'd5;
   localparam logic [2:0] kind_king   = 3'd6;

   localparam int piece_value_pawn   = 100;
   localparam int piece_value_knight = 320;
   localparam int piece_value_bishop = 330;
   localparam int piece_value_rook   = 500;
   localparam int piece_value_queen  = 900;

   localparam logic [5:0] reg_ctrl      = 6'd0;
   localparam logic [5:0] reg_status    = 6'd1;
   localparam logic [5:0] reg_side      = 6'd2;
   localparam logic [5:0] reg_eval      = 6'd3;
   localparam logic [5:0] reg_rank_base = 6'd8;

   typedef struct packed {
      logic       white_to_move;
      logic [3:0] castle_mask;
      logic [3:0] en_passant_col;   // Top bit set when no e.p. file
   } side_state_t;

   typedef struct packed {
      rank_t      rank;
      logic [2:0] index;
      logic       first;
      logic       last;
   } rank_beat_t;

   typedef struct packed {
      logic legal;
      logic king_error;
      logic pawn_error;
   } check_result_t;

   typedef struct packed {
      logic        cyc;
      logic        stb;
      logic        we;
      logic [5:0]  adr;   // Word address
      logic [31:0] dat;
   } wb_req_t;

   typedef struct packed {
      logic        ack;
      logic [31:0] dat;
   } wb_rsp_t;

   // Signed worth of one square, seen from White
   function automatic int piece_score(piece_t p);
      int value;
      case (p[2:0])
         kind_pawn:   value = piece_value_pawn;
         kind_knight: value = piece_value_knight;
         kind_bishop: value = piece_value_bishop;
         kind_rook:   value = piece_value_rook;
         kind_queen:  value = piece_value_queen;
         default:     value = 0;   // King and empty codes
      endcase
      return p[3] ? -value : value;
   endfunction

endpackage

//--- hdl/vchess_ctrl_regs.sv
`timescale 1ns/1ps

module vchess_ctrl_regs
   import vchess_pkg::*;
#(
   parameter int EVAL_WIDTH = 16
)
(
   input  logic                         clk,
   input  logic                         arst_n,
   input  wb_req_t                      wb_req,
   output wb_rsp_t                      wb_rsp,
   output logic                         start,
   output logic                         soft_reset,
   output board_t                       board,
   input  logic                         busy,
   input  logic signed [EVAL_WIDTH-1:0] eval,
   input  logic                         eval_valid,
   input  check_result_t                result,
   input  logic                         result_valid
);

   logic                         ack;
   logic                         req;
   logic                         wr;
   logic                         rank_hit;
   logic [31:0]                  rd_word;
   logic [31:0]                  rd_data;
   side_state_t                  side;
   logic signed [EVAL_WIDTH-1:0] eval_q;
   check_result_t                result_q;
   logic                         done;

   assign req      = wb_req.cyc & wb_req.stb & ~ack;
   assign wr       = ack & wb_req.we;   // Applied at the end of the ack cycle
   assign rank_hit = wb_req.adr[5:3] == reg_rank_base[5:3];

   always_comb
   begin
      rd_word = '0;
      if (rank_hit)
         rd_word = board[wb_req.adr[2:0]];
      else
         case (wb_req.adr)
            reg_status: rd_word = {27'd0, result_q, done, busy};
            reg_side:   rd_word = {23'd0, side};
            reg_eval:   rd_word = 32'(eval_q);   // Sign extended
            default:    rd_word = '0;
         endcase
   end

   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
         ack <= 1'b0;
      else
         ack <= req;
   end

   always_ff @(posedge clk)
   begin
      if (req)
         rd_data <= rd_word;
   end

   assign wb_rsp.ack = ack;
   assign wb_rsp.dat = rd_data;

   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         start      <= 1'b0;
         soft_reset <= 1'b0;
      end
      else
      begin
         start      <= wr && wb_req.adr == reg_ctrl && wb_req.dat[0] && !busy;
         soft_reset <= wr && wb_req.adr == reg_ctrl && wb_req.dat[31];
      end
   end

   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         board <= '0;
         side  <= '0;
      end
      else if (soft_reset)
      begin
         board <= '0;
         side  <= '0;
      end
      else if (wr)
      begin
         if (rank_hit)
            board[wb_req.adr[2:0]] <= wb_req.dat;
         else if (wb_req.adr == reg_side)
            side <= wb_req.dat[8:0];
      end
   end

   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         eval_q   <= '0;
         result_q <= '0;
         done     <= 1'b0;
      end
      else if (soft_reset)
      begin
         eval_q   <= '0;
         result_q <= '0;
         done     <= 1'b0;
      end
      else
      begin
         if (start)
            done <= 1'b0;
         else if (eval_valid)
            done <= 1'b1;
         if (eval_valid)
            eval_q <= eval;
         if (result_valid)
            result_q <= result;
      end
   end

endmodule

//--- hdl/board_scan.sv
`timescale 1ns/1ps

module board_scan
   import vchess_pkg::*;
(
   input  logic       clk,
   input  logic       arst_n,
   input  logic       start,
   input  logic       soft_reset,
   input  board_t     board,
   output logic       beat_valid,
   output rank_beat_t beat,
   output logic       busy
);

   board_t     snap;
   logic [2:0] cnt;
   logic       running;
   logic       tail;   // Cycle after the last beat

   always_ff @(posedge clk)
   begin
      if (start)
         snap <= board;
   end

   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         running <= 1'b0;
         cnt     <= 3'd0;
         tail    <= 1'b0;
      end
      else if (soft_reset)
      begin
         running <= 1'b0;
         cnt     <= 3'd0;
         tail    <= 1'b0;
      end
      else
      begin
         tail <= running && cnt == 3'd7;
         if (start)
         begin
            running <= 1'b1;
            cnt     <= 3'd0;
         end
         else if (running)
         begin
            cnt <= cnt + 3'd1;   // Wraps back to rank 1
            if (cnt == 3'd7)
               running <= 1'b0;
         end
      end
   end

   assign beat_valid = running;
   assign beat.rank  = snap[cnt];
   assign beat.index = cnt;
   assign beat.first = cnt == 3'd0;
   assign beat.last  = cnt == 3'd7;
   assign busy       = start | running | tail;

endmodule

//--- hdl/material_eval.sv
`timescale 1ns/1ps

module material_eval
   import vchess_pkg::*;
#(
   parameter int EVAL_WIDTH = 16
)
(
   input  logic                         clk,
   input  logic                         arst_n,
   input  logic                         soft_reset,
   input  logic                         beat_valid,
   input  rank_beat_t                   beat,
   output logic signed [EVAL_WIDTH-1:0] eval,
   output logic                         eval_valid
);

   logic signed [EVAL_WIDTH-1:0] acc;
   logic signed [EVAL_WIDTH-1:0] acc_base;
   logic signed [EVAL_WIDTH-1:0] acc_next;
   int                           rank_sum;

   always_comb
   begin
      rank_sum = 0;
      for (int i = 0; i < 8; i++)
         rank_sum += piece_score(beat.rank[i]);
      acc_base = beat.first ? '0 : acc;   // New board restarts the sum
      acc_next = acc_base + EVAL_WIDTH'(rank_sum);
   end

   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         acc        <= '0;
         eval       <= '0;
         eval_valid <= 1'b0;
      end
      else if (soft_reset)
      begin
         acc        <= '0;
         eval       <= '0;
         eval_valid <= 1'b0;
      end
      else
      begin
         eval_valid <= beat_valid && beat.last;
         if (beat_valid)
         begin
            acc <= acc_next;
            if (beat.last)
               eval <= acc_next;
         end
      end
   end

endmodule

//--- hdl/position_check.sv
`timescale 1ns/1ps

module position_check
   import vchess_pkg::*;
(
   input  logic          clk,
   input  logic          arst_n,
   input  logic          soft_reset,
   input  logic          beat_valid,
   input  rank_beat_t    beat,
   output check_result_t result,
   output logic          result_valid
);

   logic [1:0] white_kings;
   logic [1:0] black_kings;
   logic       pawn_bad;
   logic [1:0] white_next;
   logic [1:0] black_next;
   logic       pawn_next;
   logic       edge_rank;
   logic       king_err;

   assign edge_rank = beat.index == 3'd0 || beat.index == 3'd7;

   always_comb
   begin
      white_next = beat.first ? 2'd0 : white_kings;
      black_next = beat.first ? 2'd0 : black_kings;
      pawn_next  = beat.first ? 1'b0 : pawn_bad;
      for (int i = 0; i < 8; i++)
      begin
         if (beat.rank[i][2:0] == kind_king)
         begin
            if (beat.rank[i][3] && black_next != 2'd3)
               black_next = black_next + 2'd1;
            else if (!beat.rank[i][3] && white_next != 2'd3)
               white_next = white_next + 2'd1;   // Saturates at 3
         end
         if (beat.rank[i][2:0] == kind_pawn && edge_rank)
            pawn_next = 1'b1;
      end
      king_err = white_next != 2'd1 || black_next != 2'd1;
   end

   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         white_kings  <= 2'd0;
         black_kings  <= 2'd0;
         pawn_bad     <= 1'b0;
         result       <= '0;
         result_valid <= 1'b0;
      end
      else if (soft_reset)
      begin
         white_kings  <= 2'd0;
         black_kings  <= 2'd0;
         pawn_bad     <= 1'b0;
         result       <= '0;
         result_valid <= 1'b0;
      end
      else
      begin
         result_valid <= beat_valid && beat.last;
         if (beat_valid)
         begin
            white_kings <= white_next;
            black_kings <= black_next;
            pawn_bad    <= pawn_next;
            if (beat.last)
            begin
               result.legal      <= !(king_err || pawn_next);
               result.king_error <= king_err;
               result.pawn_error <= pawn_next;
            end
         end
      end
   end

endmodule

//--- hdl/vchess_top.sv
`timescale 1ns/1ps

module vchess_top
   import vchess_pkg::*;
#(
   parameter int EVAL_WIDTH = 16
)
(
   input  logic    clk,
   input  logic    arst_n,
   input  wb_req_t wb_req,
   output wb_rsp_t wb_rsp
);

   logic                         start;
   logic                         soft_reset;
   board_t                       board;
   logic                         busy;
   logic                         beat_valid;
   rank_beat_t                   beat;
   logic signed [EVAL_WIDTH-1:0] eval;
   logic                         eval_valid;
   check_result_t                result;
   logic                         result_valid;

   vchess_ctrl_regs #(
      .EVAL_WIDTH (EVAL_WIDTH)
   ) u_ctrl_regs (
      .clk          (clk),
      .arst_n       (arst_n),
      .wb_req       (wb_req),
      .wb_rsp       (wb_rsp),
      .start        (start),
      .soft_reset   (soft_reset),
      .board        (board),
      .busy         (busy),
      .eval         (eval),
      .eval_valid   (eval_valid),
      .result       (result),
      .result_valid (result_valid)
   );

   board_scan u_board_scan (
      .clk        (clk),
      .arst_n     (arst_n),
      .start      (start),
      .soft_reset (soft_reset),
      .board      (board),
      .beat_valid (beat_valid),
      .beat       (beat),
      .busy       (busy)
   );

   material_eval #(
      .EVAL_WIDTH (EVAL_WIDTH)
   ) u_material_eval (
      .clk        (clk),
      .arst_n     (arst_n),
      .soft_reset (soft_reset),
      .beat_valid (beat_valid),
      .beat       (beat),
      .eval       (eval),
      .eval_valid (eval_valid)
   );

   position_check u_position_check (
      .clk          (clk),
      .arst_n       (arst_n),
      .soft_reset   (soft_reset),
      .beat_valid   (beat_valid),
      .beat         (beat),
      .result       (result),
      .result_valid (result_valid)
   );

endmodule

//--- verification/clk_rst_gen.sv
`timescale 1ns/1ps

module clk_rst_gen
#(
   parameter int PERIOD       = 20,
   parameter int RESET_CYCLES = 16
)
(
   output logic clk,
   output logic arst_n
);

   initial
   begin
      clk = 1'b0;
      forever #(PERIOD / 2) clk = ~clk;
   end

   initial
   begin
      arst_n = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk);
      #2 arst_n = 1'b1;   // Released off the edge
   end

endmodule

//--- verification/vchess_chk.sv
`timescale 1ns/1ps

module vchess_chk
   import vchess_pkg::*;
(
   input logic    clk,
   input logic    arst_n,
   input wb_req_t wb_req,
   input logic    ack,
   input logic    busy,
   input logic    done
);

   int fail_count = 0;

   ack_single: assert property (@(posedge clk) disable iff (!arst_n) ack |=> !ack)
   else
   begin
      $error("ack was high in two consecutive cycles");
      fail_count++;
   end

   ack_follows_stb: assert property (@(posedge clk) disable iff (!arst_n)
      (wb_req.cyc && wb_req.stb && !ack) |=> ack)
   else
   begin
      $error("ack did not follow stb within one cycle");
      fail_count++;
   end

   // Accepted start write seen in its ack cycle
   done_latency: assert property (@(posedge clk) disable iff (!arst_n)
      (ack && wb_req.we && wb_req.adr == reg_ctrl && wb_req.dat[0] && !wb_req.dat[31] && !busy)
      |-> ##11 $rose(done))
   else
   begin
      $error("done did not rise 11 cycles after the start write ack");
      fail_count++;
   end

   idle_after_reset: assert property (@(posedge clk) $rose(arst_n) |-> !busy && !done)
   else
   begin
      $error("busy or done set right after reset");
      fail_count++;
   end

endmodule

bind vchess_ctrl_regs vchess_chk u_chk (
   .clk    (clk),
   .arst_n (arst_n),
   .wb_req (wb_req),
   .ack    (ack),
   .busy   (busy),
   .done   (done)
);

//--- verification/vchess_tb.sv
`timescale 1ns/1ps

module vchess_tb
   import vchess_pkg::*;
();

   localparam int n_random     = 12;
   localparam int n_tests      = n_random + 12;   // Fixed tests counted per check group
   localparam int test_cycles  = 40;
   localparam int reset_cycles = 16;
   localparam int ack_limit    = 8;
   localparam int poll_limit   = 20;

   logic    clk;
   logic    arst_n;
   wb_req_t wb_req;
   wb_rsp_t wb_rsp;
   int      errors;

   clk_rst_gen #(
      .PERIOD       (20),
      .RESET_CYCLES (reset_cycles)
   ) u_clk_rst_gen (
      .clk    (clk),
      .arst_n (arst_n)
   );

   vchess_top #(
      .EVAL_WIDTH (16)
   ) DUT (
      .clk    (clk),
      .arst_n (arst_n),
      .wb_req (wb_req),
      .wb_rsp (wb_rsp)
   );

   // One classic cycle, entered 2 ns after an edge
   task automatic bus_access(input logic we, input logic [5:0] adr, input logic [31:0] wdat,
                             output logic [31:0] rdat);
      int waits;
      wb_req.cyc = 1'b1;
      wb_req.stb = 1'b1;
      wb_req.we  = we;
      wb_req.adr = adr;
      wb_req.dat = wdat;
      waits      = 0;
      do
      begin
         @(posedge clk);
         #1;
         waits++;
      end
      while (!wb_rsp.ack && waits < ack_limit);
      if (!wb_rsp.ack)
      begin
         $display("Bus error: no ack for the access to word address %0d", adr);
         errors++;
      end
      rdat = wb_rsp.dat;
      @(posedge clk);
      #2;
      wb_req = '0;
   endtask

   task automatic write_reg(input logic [5:0] adr, input logic [31:0] dat);
      logic [31:0] unused;
      bus_access(1'b1, adr, dat, unused);
   endtask

   task automatic read_reg(input logic [5:0] adr, output logic [31:0] dat);
      bus_access(1'b0, adr, 32'h0, dat);
   endtask

   task automatic compare_word(input string what, input logic [31:0] got, input logic [31:0] exp);
      assert (got === exp)
      else
      begin
         $display("ERROR %0t: %s read 0x%08h, expected 0x%08h", $time, what, got, exp);
         errors++;
      end
   endtask

   // White minus Black, straight from the value table
   function automatic int expected_eval(board_t b);
      int     sum;
      int     value;
      piece_t p;
      sum = 0;
      for (int r = 0; r < 8; r++)
         for (int f = 0; f < 8; f++)
         begin
            p = b[r][f];
            case (p[2:0])
               kind_pawn:   value = piece_value_pawn;
               kind_knight: value = piece_value_knight;
               kind_bishop: value = piece_value_bishop;
               kind_rook:   value = piece_value_rook;
               kind_queen:  value = piece_value_queen;
               default:     value = 0;
            endcase
            sum = p[3] ? sum - value : sum + value;
         end
      return sum;
   endfunction

   // Returns legal, king_error, pawn_error
   function automatic logic [2:0] expected_flags(board_t b);
      int     white_kings;
      int     black_kings;
      logic   pawn_err;
      logic   king_err;
      piece_t p;
      white_kings = 0;
      black_kings = 0;
      pawn_err    = 1'b0;
      for (int r = 0; r < 8; r++)
         for (int f = 0; f < 8; f++)
         begin
            p = b[r][f];
            if (p[2:0] == kind_king && p[3])
               black_kings++;
            else if (p[2:0] == kind_king)
               white_kings++;
            if (p[2:0] == kind_pawn && (r == 0 || r == 7))
               pawn_err = 1'b1;
         end
      king_err = white_kings != 1 || black_kings != 1;
      return {!(king_err || pawn_err), king_err, pawn_err};
   endfunction

   function automatic board_t standard_board();
      board_t b;
      b    = '0;
      b[0] = 32'h4236_5324;
      b[1] = 32'h1111_1111;
      b[6] = 32'h9999_9999;
      b[7] = 32'hcabe_dbac;
      return b;
   endfunction

   // One king each, pawns kept off the back ranks
   function automatic board_t random_board();
      board_t     b;
      int         wk;
      int         bk;
      int         pick;
      logic [2:0] kind;
      piece_t     odd_empty [3];
      odd_empty = '{4'h7, 4'h8, 4'hf};
      b = '0;
      for (int sq = 0; sq < 64; sq++)
      begin
         pick = $urandom_range(9, 0);
         if (pick < 2)
         begin
            kind = 3'($urandom_range(5, 1));
            if (kind == kind_pawn && (sq < 8 || sq >= 56))
               kind = kind_knight;
            b[sq / 8][sq % 8] = {1'($urandom_range(1, 0)), kind};
         end
         else if (pick == 2)
            b[sq / 8][sq % 8] = odd_empty[$urandom_range(2, 0)];   // Codes that count as empty
      end
      wk = $urandom_range(63, 0);
      do
         bk = $urandom_range(63, 0);
      while (bk == wk);
      b[wk / 8][wk % 8] = {1'b0, kind_king};
      b[bk / 8][bk % 8] = {1'b1, kind_king};
      return b;
   endfunction

   task automatic load_board(input board_t b);
      for (int r = 0; r < 8; r++)
         write_reg(reg_rank_base + 6'(r), b[r]);
   endtask

   task automatic wait_done();
      logic [31:0] st;
      int          polls;
      polls = 0;
      do
      begin
         read_reg(reg_status, st);
         polls++;
      end
      while (!(st[1] && !st[0]) && polls < poll_limit);
      if (!(st[1] && !st[0]))
      begin
         $display("Analysis did not finish: done never set in the status word");
         errors++;
      end
   endtask

   task automatic verify_result(input board_t b, input string name);
      logic [31:0] got;
      read_reg(reg_eval, got);
      compare_word({name, " eval"}, got, expected_eval(b));
      read_reg(reg_status, got);
      compare_word({name, " status"}, got, {27'd0, expected_flags(b), 2'b10});
   endtask

   task automatic run_board(input board_t b, input string name);
      load_board(b);
      write_reg(reg_ctrl, 32'h1);
      wait_done();
      verify_result(b, name);
   endtask

   initial
   begin
      repeat (n_tests * test_cycles + reset_cycles) @(posedge clk);
      $display("Watchdog timeout: the tests did not finish in time");
      $display("** FAIL **");
      $finish;
   end

   initial
   begin
      board_t      b;
      board_t      next_b;
      logic [31:0] got;
      logic [8:0]  side;
      logic [5:0]  unmapped [6];
      wb_req   = '0;
      errors   = 0;
      unmapped = '{6'd0, 6'd4, 6'd5, 6'd7, 6'd16, 6'd63};
      void'($urandom(32'h83c8_9414));
      @(posedge arst_n);
      @(posedge clk);
      #2;

      read_reg(reg_status, got);
      compare_word("status after reset", got, 32'h0);
      for (int r = 0; r < 8; r++)
         b[r] = $urandom();
      load_board(b);
      for (int r = 0; r < 8; r++)
      begin
         read_reg(reg_rank_base + 6'(r), got);
         compare_word("rank readback", got, b[r]);
      end
      write_reg(reg_side, 32'hffff_ffff);
      read_reg(reg_side, got);
      compare_word("side readback", got, 32'h1ff);   // Only 9 bits stored
      side = 9'($urandom());
      write_reg(reg_side, {23'd0, side});
      read_reg(reg_side, got);
      compare_word("side readback", got, {23'd0, side});
      for (int i = 0; i < 6; i++)
      begin
         read_reg(unmapped[i], got);
         compare_word("unmapped address", got, 32'h0);
      end

      write_reg(reg_side, 32'h1f8);
      run_board(standard_board(), "standard position");

      repeat (n_random)
      begin
         write_reg(reg_side, 32'($urandom_range(511, 0)));
         run_board(random_board(), "random board");
      end

      b       = standard_board();
      b[7][4] = 4'h0;
      run_board(b, "missing black king");
      b       = standard_board();
      b[7][0] = {1'b0, kind_pawn};
      run_board(b, "pawn on rank 8");

      b      = random_board();
      next_b = random_board();
      load_board(b);
      write_reg(reg_ctrl, 32'h1);
      for (int r = 5; r < 8; r++)
         write_reg(reg_rank_base + 6'(r), next_b[r]);   // Lands while the scan runs
      write_reg(reg_ctrl, 32'h1);   // Dropped, scan still busy
      wait_done();
      verify_result(b, "snapshot run");
      for (int r = 5; r < 8; r++)
         b[r] = next_b[r];
      write_reg(reg_ctrl, 32'h1);
      wait_done();
      verify_result(b, "run after snapshot");

      write_reg(reg_ctrl, 32'h8000_0000);
      @(posedge clk);   // Pulse clears the registers one edge later
      #2;
      read_reg(reg_status, got);
      compare_word("status after soft reset", got, 32'h0);
      for (int r = 0; r < 8; r++)
      begin
         read_reg(reg_rank_base + 6'(r), got);
         compare_word("rank after soft reset", got, 32'h0);
      end
      read_reg(reg_side, got);
      compare_word("side after soft reset", got, 32'h0);
      read_reg(reg_eval, got);
      compare_word("eval after soft reset", got, 32'h0);

      repeat (2) @(posedge clk);
      $display("Done: %0d check errors, %0d assertion failures",
               errors, DUT.u_ctrl_regs.u_chk.fail_count);
      if (errors == 0 && DUT.u_ctrl_regs.u_chk.fail_count == 0)
         $display("** PASS **");
      else
         $display("** FAIL **");
      $finish;
   end

endmodule

//--- sources.f
hdl/vchess_pkg.sv
hdl/vchess_ctrl_regs.sv
hdl/board_scan.sv
hdl/material_eval.sv
hdl/position_check.sv
hdl/vchess_top.sv
verification/clk_rst_gen.sv
verification/vchess_chk.sv
verification/vchess_tb.sv

//--- Bender.yml
package:
  name: vchess

sources:
  - hdl/vchess_pkg.sv
  - hdl/vchess_ctrl_regs.sv
  - hdl/board_scan.sv
  - hdl/material_eval.sv
  - hdl/position_check.sv
  - hdl/vchess_top.sv
  - target: simulation
    files:
      - verification/clk_rst_gen.sv
      - verification/vchess_chk.sv
      - verification/vchess_tb.sv
